/* src.f */
src/rv_pkg.sv
src/decoder.sv
src/reg_file.sv
src/exec_stage.sv
src/core_top.sv
dv/tb_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_core.sv */
`timescale 1ns/100ps

module tb_core import rv_pkg::*; ();

    localparam logic [6:0] OP_I     = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;

    localparam int TABLE_ROWS  = 42;
    localparam int STALL_ROWS  = 20;
    localparam int MAX_STALLS  = 2 * STALL_ROWS; // Two LFSR bits per row.
    localparam int CYCLE_LIMIT = 4 + TABLE_ROWS + STALL_ROWS + 1 + MAX_STALLS + 20;

    typedef struct packed {
        word_t     instr;
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
        logic      we;
        logic      taken;
        exc_t      exc;
    } row_t;

    logic        d_clk;
    logic        d_rst;
    logic        instr_ce;
    word_t       instr;
    word_t       pc;
    logic        stall;
    logic        flush;
    wb_bundle_t  wb;
    logic        wb_ce;
    logic        flush_out;
    logic        hold;

    row_t        tbl [$];
    int          exp_q [$];
    logic [31:0] lfsr_state;
    int          value_errs;
    int          proto_errs;
    int          cycles;
    int          chk_row;
    int          drain;
    logic        stall_prev;

    core_top UUT (
        .d_clk     (d_clk),
        .d_rst     (d_rst),
        .instr_ce  (instr_ce),
        .instr     (instr),
        .pc        (pc),
        .stall     (stall),
        .flush     (flush),
        .wb        (wb),
        .wb_ce     (wb_ce),
        .flush_out (flush_out),
        .hold      (hold)
    );

    initial d_clk = 1'b0;
    always #4 d_clk = ~d_clk;

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    funct3_t f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_b(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2);
        return {7'b0, rs2, rs1, f3, 4'b0100, 1'b0, 7'b1100011}; // Offset +8.
    endfunction

    function automatic word_t enc_j(reg_addr_t rd);
        return {1'b0, 10'd8, 1'b0, 8'd0, rd, 7'b1101111}; // Offset +16.
    endfunction

    // Taps 32, 22, 2, 1.
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic add_row(input word_t ins, input reg_addr_t rd, input word_t data,
                           input logic we, input logic taken, input exc_t exc);
        row_t r;
        r.instr = ins;
        r.pc    = 32'h100 + word_t'(4 * tbl.size());
        r.rd    = rd;
        r.data  = data;
        r.we    = we;
        r.taken = taken;
        r.exc   = exc;
        tbl.push_back(r);
    endtask

    task automatic load_table();
        add_row(enc_i(12'h005, 5'd0, 3'b000, 5'd1, OP_I), 5'd1, 32'h5, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'hFFD, 5'd0, 3'b000, 5'd2, OP_I), 5'd2, 32'hFFFFFFFD, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h2, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 5'd4, 32'hFFFFFFFD, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd1, 5'd4, 3'b010, 5'd5), 5'd5, 32'h1, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd1, 5'd4, 3'b011, 5'd6), 5'd6, 32'h0, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 5'd7, 32'hFFFFFFF8, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd3, 5'd1, 3'b110, 5'd8), 5'd8, 32'h7, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd8, 5'd2, 3'b111, 5'd9), 5'd9, 32'h5, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd3, 5'd1, 3'b001, 5'd10), 5'd10, 32'h14, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b101, 5'd11), 5'd11, 32'h3FFFFFFF, 1'b1, 1'b0, 4'b0);
        add_row(enc_r(7'h20, 5'd3, 5'd2, 3'b101, 5'd12), 5'd12, 32'hFFFFFFFF, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h000, 5'd4, 3'b010, 5'd13, OP_I), 5'd13, 32'h1, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h006, 5'd1, 3'b011, 5'd14, OP_I), 5'd14, 32'h1, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h0FF, 5'd1, 3'b100, 5'd15, OP_I), 5'd15, 32'hFA, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h100, 5'd15, 3'b110, 5'd16, OP_I), 5'd16, 32'h1FA, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h0F0, 5'd16, 3'b111, 5'd17, OP_I), 5'd17, 32'hF0, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h004, 5'd1, 3'b001, 5'd18, OP_I), 5'd18, 32'h50, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h01C, 5'd2, 3'b101, 5'd19, OP_I), 5'd19, 32'hF, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h401, 5'd2, 3'b101, 5'd20, OP_I), 5'd20, 32'hFFFFFFFE, 1'b1, 1'b0, 4'b0);
        // Upper immediates and links, PC of row n is 0x100 + 4n.
        add_row(enc_u(20'h12345, 5'd21, OP_LUI), 5'd21, 32'h12345000, 1'b1, 1'b0, 4'b0);
        add_row(enc_u(20'h00001, 5'd22, OP_AUIPC), 5'd22, 32'h1154, 1'b1, 1'b0, 4'b0);
        add_row(enc_j(5'd23), 5'd23, 32'h15C, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h000, 5'd1, 3'b000, 5'd24, OP_JALR), 5'd24, 32'h160, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h007, 5'd1, 3'b000, 5'd0, OP_I), 5'd0, 32'h0, 1'b0, 1'b0, 4'b0);
        add_row(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd25), 5'd25, 32'h5, 1'b1, 1'b0, 4'b0);
        add_row(enc_u(20'hFFFFF, 5'd0, OP_LUI), 5'd0, 32'h0, 1'b0, 1'b0, 4'b0);
        add_row(enc_i(12'h009, 5'd0, 3'b000, 5'd26, OP_I), 5'd26, 32'h9, 1'b1, 1'b0, 4'b0);
        // Branches on x1 = 5, x2 = x4 = -3.
        add_row(enc_b(3'b000, 5'd2, 5'd4), 5'd0, 32'h0, 1'b0, 1'b1, 4'b0);
        add_row(enc_b(3'b001, 5'd1, 5'd2), 5'd0, 32'h0, 1'b0, 1'b1, 4'b0);
        add_row(enc_b(3'b100, 5'd1, 5'd2), 5'd0, 32'h0, 1'b0, 1'b0, 4'b0);
        add_row(enc_b(3'b101, 5'd1, 5'd2), 5'd0, 32'h0, 1'b0, 1'b1, 4'b0);
        add_row(enc_b(3'b110, 5'd1, 5'd2), 5'd0, 32'h0, 1'b0, 1'b1, 4'b0);
        add_row(enc_b(3'b111, 5'd1, 5'd2), 5'd0, 32'h0, 1'b0, 1'b0, 4'b0);
        add_row(32'h0000000B, 5'd0, 32'h0, 1'b0, 1'b0, 4'b0001);
        add_row(enc_i(12'h021, 5'd1, 3'b001, 5'd27, OP_I), 5'd27, 32'h0, 1'b0, 1'b0, 4'b0001);
        add_row(32'h00100073, 5'd0, 32'h0, 1'b0, 1'b0, 4'b0100);
        add_row(32'h30200073, 5'd0, 32'h0, 1'b0, 1'b0, 4'b1000);
        add_row(32'h00000073, 5'd0, 32'h0, 1'b0, 1'b0, 4'b0010);
        add_row(enc_r(7'h00, 5'd0, 5'd27, 3'b000, 5'd28), 5'd28, 32'h0, 1'b1, 1'b0, 4'b0);
        // Flushed row, then a reader of its target.
        add_row(enc_i(12'h077, 5'd0, 3'b000, 5'd29, OP_I), 5'd29, 32'h77, 1'b1, 1'b0, 4'b0);
        add_row(enc_i(12'h001, 5'd29, 3'b000, 5'd30, OP_I), 5'd30, 32'h1, 1'b1, 1'b0, 4'b0);
    endtask

    task automatic report_value(input int idx, input string what, input word_t got,
                                input word_t exp);
        $display("** Error at time %0t: row %0d %s is %h, expected %h",
                 $time, idx, what, got, exp);
        value_errs++;
    endtask

    task automatic check_result(input int idx);
        row_t r;
        r = tbl[idx];
        if (wb.pc !== r.pc) report_value(idx, "pc", wb.pc, r.pc);
        if (wb.we !== r.we) report_value(idx, "we", word_t'(wb.we), word_t'(r.we));
        if (wb.taken !== r.taken) report_value(idx, "taken", word_t'(wb.taken), word_t'(r.taken));
        if (wb.exc !== r.exc) report_value(idx, "exc", word_t'(wb.exc), word_t'(r.exc));
        if (r.we && wb.rd !== r.rd) report_value(idx, "rd", word_t'(wb.rd), word_t'(r.rd));
        if (r.we && wb.data !== r.data) report_value(idx, "data", wb.data, r.data);
        if (flush_out !== r.exc[EXC_ECALL]) begin
            report_value(idx, "flush_out", word_t'(flush_out), word_t'(r.exc[EXC_ECALL]));
        end
    endtask

    task automatic drive_row(input int idx, input logic expect_wb);
        @(posedge d_clk);
        #1;
        instr_ce = 1'b1;
        instr    = tbl[idx].instr;
        pc       = tbl[idx].pc;
        stall    = 1'b0;
        flush    = 1'b0;
        if (expect_wb) exp_q.push_back(idx);
    endtask

    task automatic drive_stalled(input int idx);
        @(posedge d_clk);
        #1;
        instr_ce = 1'b1;
        instr    = tbl[idx].instr;
        pc       = tbl[idx].pc;
        stall    = 1'b1;
        flush    = 1'b0;
    endtask

    task automatic idle_cycle(input logic fl);
        @(posedge d_clk);
        #1;
        instr_ce = 1'b0;
        stall    = 1'b0;
        flush    = fl;
    endtask

    task automatic run_rows(input int first, input int last, input logic with_stall);
        for (int i = first; i <= last; i++) begin
            if (with_stall) begin
                for (int k = 0; k < 2; k++) begin
                    if (rand_bit()) drive_stalled(i);
                end
            end
            drive_row(i, 1'b1);
        end
    endtask

    // Mid-cycle sampling, inputs move 1 ns after the rising edge.
    always @(negedge d_clk) begin
        if (d_rst) begin
            if (hold !== stall) begin
                $display("** Error at time %0t: hold is %b, stall is %b", $time, hold, stall);
                value_errs++;
            end
            if (stall_prev && wb_ce) begin
                $display("wb_ce went high at an edge where stall was high, time %0t", $time);
                proto_errs++;
            end
            if (wb_ce) begin
                if (exp_q.size() == 0) begin
                    $display("wb_ce is high but no row is outstanding, time %0t", $time);
                    proto_errs++;
                end else begin
                    chk_row = exp_q.pop_front();
                    check_result(chk_row);
                end
            end else if (flush_out !== 1'b0) begin
                $display("** Error at time %0t: flush_out is high without wb_ce", $time);
                value_errs++;
            end
            stall_prev = stall;
        end
    end

    always @(posedge d_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        d_rst      = 1'b0;
        instr_ce   = 1'b0;
        instr      = '0;
        pc         = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        lfsr_state = 32'h3a33;
        value_errs = 0;
        proto_errs = 0;
        cycles     = 0;
        drain      = 0;
        stall_prev = 1'b0;
        load_table();
        repeat (4) @(posedge d_clk);
        if (wb_ce !== 1'b0 || flush_out !== 1'b0 || hold !== 1'b0) begin
            $display("Outputs are not low while reset is asserted");
            proto_errs++;
        end
        #1;
        d_rst = 1'b1;
        run_rows(0, 39, 1'b0);
        run_rows(0, STALL_ROWS - 1, 1'b1);
        drive_row(40, 1'b0); // In decode when the flush pulse arrives.
        idle_cycle(1'b1);
        drive_row(41, 1'b1);
        while (exp_q.size() != 0 && drain < 10) begin
            idle_cycle(1'b0);
            drain++;
        end
        repeat (2) idle_cycle(1'b0);
        if (exp_q.size() != 0) begin
            $display("Missing wb_ce: %0d rows never came out, first is row %0d",
                     exp_q.size(), exp_q[0]);
            proto_errs += exp_q.size();
        end
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* src/core_top.sv */
`timescale 1ns/100ps

module core_top import rv_pkg::*; (
    input  logic       d_clk,
    input  logic       d_rst,
    input  logic       instr_ce,
    input  word_t      instr,
    input  word_t      pc,
    input  logic       stall,
    input  logic       flush,
    output wb_bundle_t wb,
    output logic       wb_ce,
    output logic       flush_out,
    output logic       hold
);

    dec_bundle_t dec;
    logic        dec_ce;
    word_t       rs1_data;
    word_t       rs2_data;

    decoder u_dec (
        .d_clk    (d_clk),
        .d_rst    (d_rst),
        .instr_ce (instr_ce),
        .instr    (instr),
        .pc       (pc),
        .stall    (stall),
        .flush    (flush),
        .dec      (dec),
        .dec_ce   (dec_ce)
    );

    reg_file u_rf (
        .d_clk    (d_clk),
        .d_rst    (d_rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb.we),
        .rd       (wb.rd),
        .rd_data  (wb.data)
    );

    exec_stage u_exe (
        .d_clk    (d_clk),
        .d_rst    (d_rst),
        .dec      (dec),
        .dec_ce   (dec_ce),
        .stall    (stall),
        .flush    (flush),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb),
        .wb_ce    (wb_ce)
    );

    assign flush_out = wb_ce && wb.exc[EXC_ECALL];
    assign hold      = stall;

endmodule

/* src/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage import rv_pkg::*; (
    input  logic        d_clk,
    input  logic        d_rst,
    input  dec_bundle_t dec,
    input  logic        dec_ce,
    input  logic        stall,
    input  logic        flush,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    output wb_bundle_t  wb,
    output logic        wb_ce
);

    word_t      op_a;
    word_t      rs2_val;
    word_t      op_b;
    word_t      alu_res;
    logic       cmp;
    logic       writes;
    wb_bundle_t wb_d;

    // Previous result is not yet in the register file.
    assign op_a    = (wb.we && wb.rd == dec.rs1) ? wb.data : rs1_data;
    assign rs2_val = (wb.we && wb.rd == dec.rs2) ? wb.data : rs2_data;
    assign op_b    = (dec.op_class[OPC_RTYPE] || dec.op_class[OPC_BRANCH]) ? rs2_val : dec.imm;

    always_comb begin
        alu_res = '0;
        if (dec.alu[ALU_ADD])  alu_res = op_a + op_b;
        if (dec.alu[ALU_SUB])  alu_res = op_a - op_b;
        if (dec.alu[ALU_SLT])  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
        if (dec.alu[ALU_SLTU]) alu_res = {31'b0, op_a < op_b};
        if (dec.alu[ALU_XOR])  alu_res = op_a ^ op_b;
        if (dec.alu[ALU_OR])   alu_res = op_a | op_b;
        if (dec.alu[ALU_AND])  alu_res = op_a & op_b;
        if (dec.alu[ALU_SLL])  alu_res = op_a << op_b[4:0];
        if (dec.alu[ALU_SRL])  alu_res = op_a >> op_b[4:0];
        if (dec.alu[ALU_SRA])  alu_res = $signed(op_a) >>> op_b[4:0];

        cmp = (dec.alu[ALU_EQ]  && op_a == op_b) ||
              (dec.alu[ALU_NEQ] && op_a != op_b) ||
              (dec.alu[ALU_LT]  && $signed(op_a) < $signed(op_b)) ||
              (dec.alu[ALU_GE]  && $signed(op_a) >= $signed(op_b)) ||
              (dec.alu[ALU_LTU] && op_a < op_b) ||
              (dec.alu[ALU_GEU] && op_a >= op_b);

        writes = dec.op_class[OPC_RTYPE] || dec.op_class[OPC_ITYPE] ||
                 dec.op_class[OPC_LUI] || dec.op_class[OPC_AUIPC] ||
                 dec.op_class[OPC_JAL] || dec.op_class[OPC_JALR];

        wb_d       = '0;
        wb_d.pc    = dec.pc;
        wb_d.rd    = dec.rd;
        wb_d.exc   = dec.exc;
        wb_d.taken = dec.op_class[OPC_BRANCH] && cmp;
        wb_d.we    = dec_ce && !flush && writes && dec.rd != '0 && dec.exc == '0;

        if (dec.op_class[OPC_LUI]) begin
            wb_d.data = dec.imm;
        end else if (dec.op_class[OPC_AUIPC]) begin
            wb_d.data = dec.pc + dec.imm;
        end else if (dec.op_class[OPC_JAL] || dec.op_class[OPC_JALR]) begin
            wb_d.data = dec.pc + 32'd4; // Link address.
        end else begin
            wb_d.data = alu_res;
        end
    end

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            wb    <= '0;
            wb_ce <= 1'b0;
        end else if (stall) begin
            wb_ce <= 1'b0;
            wb.we <= 1'b0; // Result already written.
        end else begin
            wb    <= wb_d;
            wb_ce <= dec_ce && !flush;
        end
    end

    // Held instruction must survive a stall.
    a_stall_holds_dec: assert property (@(posedge d_clk) disable iff (!d_rst)
        stall |=> $stable(dec) && $stable(dec_ce));

endmodule

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
    input  logic      d_clk,
    input  logic      d_rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     rd_data
);

    word_t regs [1:REG_COUNT-1]; // No storage for x0.

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // Writeback must already have filtered x0 targets.
    a_no_x0_write: assert property (@(posedge d_clk) disable iff (!d_rst)
        we |-> rd != '0);

endmodule

/* src/decoder.sv */
`timescale 1ns/100ps

module decoder import rv_pkg::*; (
    input  logic        d_clk,
    input  logic        d_rst,
    input  logic        instr_ce,
    input  word_t       instr,
    input  word_t       pc,
    input  logic        stall,
    input  logic        flush,
    output dec_bundle_t dec,
    output logic        dec_ce
);

    dec_bundle_t dec_d;
    logic [6:0]  opcode;
    logic        sys_d;
    logic        shift_i;

    always_comb begin
        dec_d  = '0;
        opcode = instr[6:0];
        dec_d.pc = pc;

        dec_d.op_class[OPC_RTYPE]  = opcode == OPCODE_RTYPE;
        dec_d.op_class[OPC_ITYPE]  = opcode == OPCODE_ITYPE;
        dec_d.op_class[OPC_LOAD]   = opcode == OPCODE_LOAD;
        dec_d.op_class[OPC_STORE]  = opcode == OPCODE_STORE;
        dec_d.op_class[OPC_BRANCH] = opcode == OPCODE_BRANCH;
        dec_d.op_class[OPC_JAL]    = opcode == OPCODE_JAL;
        dec_d.op_class[OPC_JALR]   = opcode == OPCODE_JALR;
        dec_d.op_class[OPC_LUI]    = opcode == OPCODE_LUI;
        dec_d.op_class[OPC_AUIPC]  = opcode == OPCODE_AUIPC;
        dec_d.op_class[OPC_SYSTEM] = opcode == OPCODE_SYSTEM;
        dec_d.op_class[OPC_FENCE]  = opcode == OPCODE_FENCE;

        // Register fields depend on the format.
        if (dec_d.op_class[OPC_RTYPE]) begin
            dec_d.rs1    = instr[19:15];
            dec_d.rs2    = instr[24:20];
            dec_d.rd     = instr[11:7];
            dec_d.funct3 = instr[14:12];
        end else if (dec_d.op_class[OPC_ITYPE] || dec_d.op_class[OPC_LOAD] ||
                     dec_d.op_class[OPC_JALR] || dec_d.op_class[OPC_SYSTEM] ||
                     dec_d.op_class[OPC_FENCE]) begin
            dec_d.rs1    = instr[19:15];
            dec_d.rd     = instr[11:7];
            dec_d.funct3 = instr[14:12];
        end else if (dec_d.op_class[OPC_STORE] || dec_d.op_class[OPC_BRANCH]) begin
            dec_d.rs1    = instr[19:15];
            dec_d.rs2    = instr[24:20];
            dec_d.funct3 = instr[14:12];
        end else if (dec_d.op_class[OPC_LUI] || dec_d.op_class[OPC_AUIPC] ||
                     dec_d.op_class[OPC_JAL]) begin
            dec_d.rd = instr[11:7];
        end

        case (opcode)
            OPCODE_ITYPE, OPCODE_JALR, OPCODE_LOAD: begin
                dec_d.imm = {{20{instr[31]}}, instr[31:20]};
            end
            OPCODE_STORE: begin
                dec_d.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPCODE_BRANCH: begin
                dec_d.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPCODE_JAL: begin
                dec_d.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                dec_d.imm = {instr[31:12], 12'b0};
            end
            OPCODE_SYSTEM, OPCODE_FENCE: begin
                dec_d.imm = {20'b0, instr[31:20]}; // Zero extended CSR field.
            end
            default: begin
                dec_d.imm = '0;
            end
        endcase

        if (dec_d.op_class[OPC_RTYPE] || dec_d.op_class[OPC_ITYPE]) begin
            case (dec_d.funct3)
                FUNCT3_ADD: begin
                    // Bit 30 is immediate data for ADDI.
                    if (dec_d.op_class[OPC_RTYPE] && instr[30]) begin
                        dec_d.alu[ALU_SUB] = 1'b1;
                    end else begin
                        dec_d.alu[ALU_ADD] = 1'b1;
                    end
                end
                FUNCT3_SLL:  dec_d.alu[ALU_SLL]  = 1'b1;
                FUNCT3_SLT:  dec_d.alu[ALU_SLT]  = 1'b1;
                FUNCT3_SLTU: dec_d.alu[ALU_SLTU] = 1'b1;
                FUNCT3_XOR:  dec_d.alu[ALU_XOR]  = 1'b1;
                FUNCT3_SRL: begin
                    if (instr[30]) begin
                        dec_d.alu[ALU_SRA] = 1'b1;
                    end else begin
                        dec_d.alu[ALU_SRL] = 1'b1;
                    end
                end
                FUNCT3_OR:   dec_d.alu[ALU_OR]   = 1'b1;
                default:     dec_d.alu[ALU_AND]  = 1'b1;
            endcase
        end else if (dec_d.op_class[OPC_BRANCH]) begin
            case (dec_d.funct3)
                FUNCT3_EQ:  dec_d.alu[ALU_EQ]  = 1'b1;
                FUNCT3_NEQ: dec_d.alu[ALU_NEQ] = 1'b1;
                FUNCT3_LT:  dec_d.alu[ALU_LT]  = 1'b1;
                FUNCT3_GE:  dec_d.alu[ALU_GE]  = 1'b1;
                FUNCT3_LTU: dec_d.alu[ALU_LTU] = 1'b1;
                FUNCT3_GEU: dec_d.alu[ALU_GEU] = 1'b1;
                default:    dec_d.alu = '0; // Reserved branch funct3.
            endcase
        end else begin
            dec_d.alu[ALU_ADD] = 1'b1;
        end

        shift_i = dec_d.op_class[OPC_ITYPE] &&
                  (dec_d.funct3 == FUNCT3_SLL || dec_d.funct3 == FUNCT3_SRL);
        sys_d   = dec_d.op_class[OPC_SYSTEM] && dec_d.funct3 == FUNCT3_ADD;

        dec_d.exc[EXC_ILLEGAL] = (dec_d.op_class == '0) || (shift_i && instr[25]);
        dec_d.exc[EXC_ECALL]   = sys_d && instr[21:20] == 2'b00;
        dec_d.exc[EXC_EBREAK]  = sys_d && instr[21:20] == 2'b01;
        dec_d.exc[EXC_MRET]    = sys_d && instr[21:20] == 2'b10;
    end

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            dec    <= '0;
            dec_ce <= 1'b0;
        end else if (!stall) begin
            dec_ce <= instr_ce && !flush;
            if (instr_ce) begin
                dec <= dec_d;
            end
        end
    end

    a_alu_onehot: assert property (@(posedge d_clk) disable iff (!d_rst)
        dec_ce |-> $onehot0(dec.alu));

endmodule

/* src/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_AW    = 5;
    localparam int REG_COUNT = 32;

    localparam int ALU_WIDTH = 16;
    localparam int OPC_WIDTH = 11;
    localparam int EXC_WIDTH = 4;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_AW-1:0]    reg_addr_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [ALU_WIDTH-1:0] alu_op_t;
    typedef logic [OPC_WIDTH-1:0] op_class_t;
    typedef logic [EXC_WIDTH-1:0] exc_t;

    // Bit positions inside alu_op_t.
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_XOR  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_AND  = 6;
    localparam int ALU_SLL  = 7;
    localparam int ALU_SRL  = 8;
    localparam int ALU_SRA  = 9;
    localparam int ALU_EQ   = 10;
    localparam int ALU_NEQ  = 11;
    localparam int ALU_LT   = 12;
    localparam int ALU_GE   = 13;
    localparam int ALU_LTU  = 14;
    localparam int ALU_GEU  = 15;

    localparam int OPC_RTYPE  = 0;
    localparam int OPC_ITYPE  = 1;
    localparam int OPC_LOAD   = 2;
    localparam int OPC_STORE  = 3;
    localparam int OPC_BRANCH = 4;
    localparam int OPC_JAL    = 5;
    localparam int OPC_JALR   = 6;
    localparam int OPC_LUI    = 7;
    localparam int OPC_AUIPC  = 8;
    localparam int OPC_SYSTEM = 9;
    localparam int OPC_FENCE  = 10;

    localparam int EXC_ILLEGAL = 0;
    localparam int EXC_ECALL   = 1;
    localparam int EXC_EBREAK  = 2;
    localparam int EXC_MRET    = 3;

    localparam logic [6:0] OPCODE_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPCODE_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPCODE_FENCE  = 7'b0001111;

    localparam funct3_t FUNCT3_ADD  = 3'b000;
    localparam funct3_t FUNCT3_SLL  = 3'b001;
    localparam funct3_t FUNCT3_SLT  = 3'b010;
    localparam funct3_t FUNCT3_SLTU = 3'b011;
    localparam funct3_t FUNCT3_XOR  = 3'b100;
    localparam funct3_t FUNCT3_SRL  = 3'b101; // SRA too, split by bit 30.
    localparam funct3_t FUNCT3_OR   = 3'b110;
    localparam funct3_t FUNCT3_AND  = 3'b111;
    localparam funct3_t FUNCT3_EQ   = 3'b000;
    localparam funct3_t FUNCT3_NEQ  = 3'b001;
    localparam funct3_t FUNCT3_LT   = 3'b100;
    localparam funct3_t FUNCT3_GE   = 3'b101;
    localparam funct3_t FUNCT3_LTU  = 3'b110;
    localparam funct3_t FUNCT3_GEU  = 3'b111;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        funct3_t   funct3;
        alu_op_t   alu;
        op_class_t op_class;
        exc_t      exc;
    } dec_bundle_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
        logic      we;
        logic      taken;
        exc_t      exc;
    } wb_bundle_t;

endpackage
